//--- verilog/bp_pkg.sv
package bp_pkg;

    localparam int PC_W        = 32;
    localparam int BTB_INDEX_W = 6;            // 64 entries indexed by pc[8:3]
    localparam int BTB_TAG_W   = 8;            // pc[16:9]
    localparam int PHT_INDEX_W = 8;            // 256 counters
    localparam int GHR_W       = PHT_INDEX_W;  // history xor'ed straight onto the index

    // branch kind as delivered by predecode / execute
    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_UNCOND   = 2'd1,
        BR_COND     = 2'd2,
        BR_INDIRECT = 2'd3  // also unconditional
    } br_kind_e;

    // 2-bit saturating counter from 0 strong not-taken up to 3 strong taken
    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_T    = 2'd2;  // taken threshold
    localparam ctr_t CTR_STRONG_T  = 2'd3;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        br_kind_e             kind;
        logic [PC_W-1:0]      target;
    } btb_entry_t;

    // returned with the resolve so the update never reads the tables
    typedef struct packed {
        logic [PHT_INDEX_W-1:0] pht_index;
        ctr_t                   ctr;
    } bp_meta_t;

    typedef struct packed {
        logic [PC_W-1:0] pred_pc;
        logic            taken;
        logic            hit;
        bp_meta_t        meta;
    } bp_pred_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] target;
        logic            taken;
        br_kind_e        kind;
        bp_meta_t        meta;
    } bp_resolve_t;

    // stage 1 -> stage 2 only
    typedef struct packed {
        logic [BTB_INDEX_W-1:0] btb_index;
        logic [BTB_TAG_W-1:0]   tag;
        logic [PHT_INDEX_W-1:0] pht_index;
        logic [PC_W-1:0]        seq_pc;
    } bp_lookup_req_t;

    function automatic logic [BTB_INDEX_W-1:0] btb_index_of(logic [PC_W-1:0] pc);
        return pc[BTB_INDEX_W+2:3];  // both slots of a pair share the entry
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag_of(logic [PC_W-1:0] pc);
        return pc[BTB_TAG_W+BTB_INDEX_W+2:BTB_INDEX_W+3];
    endfunction

endpackage

//--- verilog/bp_table_ram.sv
`timescale 1ns/1ps

// flop table, registered read, old data on a same-cycle write
module bp_table_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  ADDR_W  = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic [ADDR_W-1:0] raddr,
    output entry_t            rdata,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  entry_t            wdata
);

    entry_t mem [1 << ADDR_W];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << ADDR_W); i++) begin
                mem[i] <= '0;  // all entries invalid, counters strong not-taken
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // nonblocking read sees the contents before this edge's write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rstn)
        we |-> !$isunknown(waddr)
    ) else $error("table write with unknown address");

endmodule

//--- verilog/bp_fetch_index.sv
`timescale 1ns/1ps

module bp_fetch_index
    import bp_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  logic             fetch_valid,
    input  logic [PC_W-1:0]  fetch_pc,
    input  logic [GHR_W-1:0] ghr,
    output logic             req_valid,
    output bp_lookup_req_t   req
);

    bp_lookup_req_t req_d;

    // slice and hash the fetch pc
    always_comb begin
        req_d.btb_index = btb_index_of(fetch_pc);
        req_d.tag       = btb_tag_of(fetch_pc);
        // gshare hash of pc[10:3] with the history as it stands at the fetch strobe
        req_d.pht_index = fetch_pc[PHT_INDEX_W+2:3] ^ ghr;
        // second slot of a pair only steps 4 to reach the next pair
        if (fetch_pc[2]) begin
            req_d.seq_pc = fetch_pc + PC_W'(4);
        end else begin
            req_d.seq_pc = fetch_pc + PC_W'(8);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            req <= req_d;  // only meaningful alongside req_valid
        end
    end

endmodule

//--- verilog/bp_lookup.sv
`timescale 1ns/1ps

module bp_lookup
    import bp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  bp_lookup_req_t         req,
    input  logic                   btb_we,
    input  logic [BTB_INDEX_W-1:0] btb_waddr,
    input  btb_entry_t             btb_wdata,
    input  logic                   pht_we,
    input  logic [PHT_INDEX_W-1:0] pht_waddr,
    input  ctr_t                   pht_wdata,
    input  logic [BTB_INDEX_W-1:0] probe_index,
    input  logic [BTB_TAG_W-1:0]   probe_tag,
    output logic                   btb_tag_match,
    output logic                   pred_valid,
    output bp_pred_t               pred
);

    btb_entry_t     btb_rdata;
    ctr_t           pht_rdata;
    logic           req_valid_q;
    bp_lookup_req_t req_q;  // lines up with the synchronous reads
    btb_entry_t     probe_entry;
    logic           hit;
    logic           taken;
    bp_pred_t       pred_d;

    bp_table_ram #(
        .entry_t (btb_entry_t),
        .ADDR_W  (BTB_INDEX_W)
    ) u_btb_ram (
        .clk   (clk),
        .rstn  (rstn),
        .raddr (req.btb_index),
        .rdata (btb_rdata),
        .we    (btb_we),
        .waddr (btb_waddr),
        .wdata (btb_wdata)
    );

    bp_table_ram #(
        .entry_t (ctr_t),
        .ADDR_W  (PHT_INDEX_W)
    ) u_pht_ram (
        .clk   (clk),
        .rstn  (rstn),
        .raddr (req.pht_index),
        .rdata (pht_rdata),
        .we    (pht_we),
        .waddr (pht_waddr),
        .wdata (pht_wdata)
    );

    // resolve-side probe; a write still in flight to the same entry wins
    assign probe_entry   = (btb_we && btb_waddr == probe_index) ? btb_wdata
                                                               : u_btb_ram.mem[probe_index];
    assign btb_tag_match = probe_entry.valid && (probe_entry.tag == probe_tag);

    always_comb begin
        hit = btb_rdata.valid && (btb_rdata.tag == req_q.tag);
        case (btb_rdata.kind)
            BR_UNCOND, BR_INDIRECT: taken = hit;
            BR_COND:                taken = hit && (pht_rdata >= CTR_WEAK_T);
            default:                taken = 1'b0;
        endcase
        pred_d.pred_pc        = taken ? btb_rdata.target : req_q.seq_pc;
        pred_d.taken          = taken;
        pred_d.hit            = hit;
        pred_d.meta.pht_index = req_q.pht_index;
        pred_d.meta.ctr       = pht_rdata;  // counter as seen now, stepped on resolve
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_valid_q <= 1'b0;
            pred_valid  <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
            pred_valid  <= req_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
        if (req_valid_q) begin
            pred <= pred_d;
        end
    end

    a_taken_is_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        req_valid |-> ##2 (pred_valid && (!pred.taken || pred.hit))
    ) else $error("taken prediction without a BTB hit");

endmodule

//--- verilog/bp_update.sv
`timescale 1ns/1ps

module bp_update
    import bp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   resolve_valid,
    input  bp_resolve_t            resolve,
    input  logic                   btb_tag_match,
    output logic [BTB_INDEX_W-1:0] probe_index,
    output logic [BTB_TAG_W-1:0]   probe_tag,
    output logic                   btb_we,
    output logic [BTB_INDEX_W-1:0] btb_waddr,
    output btb_entry_t             btb_wdata,
    output logic                   pht_we,
    output logic [PHT_INDEX_W-1:0] pht_waddr,
    output ctr_t                   pht_wdata,
    output logic [GHR_W-1:0]       ghr
);

    logic is_cond;
    logic taken_q;  // outcome shifted into history one edge later

    // one step toward the outcome, saturating at both ends
    function automatic ctr_t ctr_step(ctr_t c, logic tkn);
        if (tkn) begin
            return (c == CTR_STRONG_T) ? c : c + ctr_t'(1);
        end
        return (c == CTR_STRONG_NT) ? c : c - ctr_t'(1);
    endfunction

    assign probe_index = btb_index_of(resolve.pc);
    assign probe_tag   = btb_tag_of(resolve.pc);
    assign is_cond     = (resolve.kind == BR_COND);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            btb_we <= 1'b0;
            pht_we <= 1'b0;
            ghr    <= '0;
        end else begin
            // allocate on taken, drop a non-branch only if it owns the entry
            btb_we <= resolve_valid &&
                      (resolve.taken || (resolve.kind == BR_NONE && btb_tag_match));
            pht_we <= resolve_valid && is_cond;
            if (pht_we) begin
                ghr <= {ghr[GHR_W-2:0], taken_q};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            btb_waddr        <= probe_index;
            btb_wdata.valid  <= resolve.taken;  // 0 for the invalidate case
            btb_wdata.tag    <= probe_tag;
            btb_wdata.kind   <= resolve.kind;
            btb_wdata.target <= resolve.target;
            pht_waddr        <= resolve.meta.pht_index;
            pht_wdata        <= ctr_step(resolve.meta.ctr, resolve.taken);
            taken_q          <= resolve.taken;
        end
    end

    a_kind_known: assert property (
        @(posedge clk) disable iff (!rstn)
        resolve_valid |-> !$isunknown(resolve.kind)
    ) else $error("resolve with unknown branch kind");

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            fetch_valid,
    input  logic [PC_W-1:0] fetch_pc,
    output logic            pred_valid,
    output bp_pred_t        pred,
    input  logic            resolve_valid,
    input  bp_resolve_t     resolve
);

    logic                   req_valid;
    bp_lookup_req_t         req;
    logic [GHR_W-1:0]       ghr;
    logic [BTB_INDEX_W-1:0] probe_index;
    logic [BTB_TAG_W-1:0]   probe_tag;
    logic                   btb_tag_match;
    logic                   btb_we;
    logic [BTB_INDEX_W-1:0] btb_waddr;
    btb_entry_t             btb_wdata;
    logic                   pht_we;
    logic [PHT_INDEX_W-1:0] pht_waddr;
    ctr_t                   pht_wdata;

    bp_fetch_index u_fetch_index (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .ghr         (ghr),
        .req_valid   (req_valid),
        .req         (req)
    );

    bp_lookup u_lookup (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .btb_we        (btb_we),
        .btb_waddr     (btb_waddr),
        .btb_wdata     (btb_wdata),
        .pht_we        (pht_we),
        .pht_waddr     (pht_waddr),
        .pht_wdata     (pht_wdata),
        .probe_index   (probe_index),
        .probe_tag     (probe_tag),
        .btb_tag_match (btb_tag_match),
        .pred_valid    (pred_valid),
        .pred          (pred)
    );

    bp_update u_update (
        .clk           (clk),
        .rstn          (rstn),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .btb_tag_match (btb_tag_match),
        .probe_index   (probe_index),
        .probe_tag     (probe_tag),
        .btb_we        (btb_we),
        .btb_waddr     (btb_waddr),
        .btb_wdata     (btb_wdata),
        .pht_we        (pht_we),
        .pht_waddr     (pht_waddr),
        .pht_wdata     (pht_wdata),
        .ghr           (ghr)
    );

endmodule

//--- verif/branch_predictor_tb.sv
`timescale 1ns/1ps

module branch_predictor_tb
    import bp_pkg::*;
();

    logic             clk;
    logic             rstn;
    logic             fetch_valid;
    logic [PC_W-1:0]  fetch_pc;
    logic             pred_valid;
    bp_pred_t         pred;
    logic             resolve_valid;
    bp_resolve_t      resolve;

    // shadow copy of the predictor state
    btb_entry_t       btb_model [1 << BTB_INDEX_W];
    ctr_t             pht_model [1 << PHT_INDEX_W];
    logic [GHR_W-1:0] ghr_model;

    bp_pred_t         exp_q [$];
    bp_pred_t         exp_head;   // expectation for the prediction on the outputs
    logic             exp_avail;
    logic [31:0]      rand_state;
    logic [PC_W-1:0]  pc_pool [8];
    string            test_name;
    int               value_errs;
    int               timing_errs;
    int               timeout_errs;

    always #20 clk = ~clk;

    branch_predictor u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .pred_valid    (pred_valid),
        .pred          (pred),
        .resolve_valid (resolve_valid),
        .resolve       (resolve)
    );

    // outputs only move on the rising edge, so the falling edge is quiet
    always @(negedge clk) begin
        if (pred_valid) begin
            exp_avail = (exp_q.size() > 0);
            if (exp_avail) begin
                exp_head = exp_q.pop_front();
            end
        end
    end

    // fetch sampled at edge n, prediction up after edge n+2
    a_pred_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        fetch_valid |-> ##3 pred_valid
    ) else begin
        timing_errs++;
        $display("prediction strobe missing after a fetch in %s", test_name);
    end

    a_pred_origin: assert property (
        @(posedge clk) disable iff (!rstn)
        pred_valid |-> $past(fetch_valid, 3)
    ) else begin
        timing_errs++;
        $display("prediction strobe without a matching fetch in %s", test_name);
    end

    a_pred_expected: assert property (
        @(posedge clk) disable iff (!rstn)
        pred_valid |-> exp_avail
    ) else begin
        timing_errs++;
        $display("prediction arrived with nothing expected in %s", test_name);
    end

    a_pred_value: assert property (
        @(posedge clk) disable iff (!rstn)
        pred_valid |-> (pred == exp_head)
    ) else begin
        value_errs++;
        $display("ERR %s: expected %h actual %h", test_name, exp_head, $sampled(pred));
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic [PC_W-1:0] random_pc();
        logic [31:0] r;
        r = next_rand();
        return pc_pool[r[18:16]] | {29'd0, r[20], 2'b00};  // either slot of the pair
    endfunction

    function automatic ctr_t step_ctr(ctr_t c, logic taken);
        int v;
        v = int'(c) + (taken ? 1 : -1);
        if (v < 0) begin
            v = 0;
        end
        if (v > 3) begin
            v = 3;
        end
        return ctr_t'(v);
    endfunction

    function automatic bp_pred_t predict(logic [PC_W-1:0] pc);
        btb_entry_t e;
        bp_pred_t   p;
        e                = btb_model[pc[8:3]];
        p.meta.pht_index = pc[10:3] ^ ghr_model;  // gshare hash
        p.meta.ctr       = pht_model[p.meta.pht_index];
        p.hit            = e.valid && (e.tag == pc[16:9]);
        p.taken          = p.hit && (e.kind == BR_UNCOND || e.kind == BR_INDIRECT ||
                                     (e.kind == BR_COND && p.meta.ctr >= 2'd2));
        p.pred_pc        = p.taken ? e.target : pc + (pc[2] ? 32'd4 : 32'd8);
        return p;
    endfunction

    task automatic issue_fetch(logic [PC_W-1:0] pc);
        exp_q.push_back(predict(pc));
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        @(posedge clk);
        #2;
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() > 0 && t < 10) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (exp_q.size() > 0) begin
            timeout_errs++;
            $display("timed out waiting for %0d predictions in %s", exp_q.size(), test_name);
            exp_q.delete();
        end
    endtask

    task automatic resolve_branch(logic [PC_W-1:0] pc, logic [PC_W-1:0] target,
                                  logic taken, br_kind_e kind, bp_meta_t meta);
        btb_entry_t e;
        e = btb_model[pc[8:3]];
        if (taken) begin
            btb_model[pc[8:3]] = '{valid: 1'b1, tag: pc[16:9], kind: kind, target: target};
        end else if (kind == BR_NONE && e.valid && e.tag == pc[16:9]) begin
            btb_model[pc[8:3]].valid = 1'b0;  // only the owner gets dropped
        end
        if (kind == BR_COND) begin
            pht_model[meta.pht_index] = step_ctr(meta.ctr, taken);
            ghr_model = {ghr_model[GHR_W-2:0], taken};
        end
        resolve_valid = 1'b1;
        resolve       = '{pc: pc, target: target, taken: taken, kind: kind, meta: meta};
        @(posedge clk);
        #2;
        resolve_valid = 1'b0;
        repeat (3) @(posedge clk);  // tables and history settle before the next fetch
        #2;
    endtask

    task automatic fetch_then_resolve(logic [PC_W-1:0] pc, logic [PC_W-1:0] target,
                                      logic taken, br_kind_e kind);
        bp_pred_t p;
        p = predict(pc);
        issue_fetch(pc);
        wait_drain();
        resolve_branch(pc, target, taken, kind, p.meta);
    endtask

    initial begin
        logic [31:0]     r;
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] pc_a;
        logic [PC_W-1:0] tgt;
        br_kind_e        kind;
        logic            tkn;
        clk           = 1'b0;
        rstn          = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        rand_state    = 32'd61690;
        value_errs    = 0;
        timing_errs   = 0;
        timeout_errs  = 0;
        exp_head      = '0;
        exp_avail     = 1'b0;
        ghr_model     = '0;
        for (int i = 0; i < (1 << BTB_INDEX_W); i++) begin
            btb_model[i] = '0;
        end
        for (int i = 0; i < (1 << PHT_INDEX_W); i++) begin
            pht_model[i] = '0;
        end
        pc_pool[0] = 32'h0000_1000;
        pc_pool[1] = 32'h0000_1048;
        pc_pool[2] = 32'h0000_2090;
        pc_pool[3] = 32'h0001_30a8;
        pc_pool[4] = 32'h0000_0200;  // same index as [0] with another tag
        pc_pool[5] = 32'h0000_4048;  // same index as [1] with another tag
        pc_pool[6] = 32'h0002_0120;
        pc_pool[7] = 32'h0000_37f8;
        test_name  = "reset";
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;

        test_name = "cold";
        for (int n = 0; n < 8; n++) begin
            issue_fetch(random_pc());  // back to back
        end
        wait_drain();

        test_name = "uncond";
        pc_a = 32'h0000_1000;
        fetch_then_resolve(pc_a, 32'h0000_8000, 1'b1, BR_UNCOND);
        fetch_then_resolve(32'h0000_2094, 32'h0000_a0c0, 1'b1, BR_INDIRECT);
        issue_fetch(pc_a);
        issue_fetch(32'h0000_2094);
        wait_drain();

        test_name = "cond_train";
        pc = 32'h0000_1048;
        for (int n = 0; n < 12; n++) begin
            fetch_then_resolve(pc, 32'h0000_0400, 1'b1, BR_COND);
        end
        for (int n = 0; n < 12; n++) begin
            fetch_then_resolve(pc, 32'h0000_0400, 1'b0, BR_COND);
        end
        issue_fetch(pc);
        wait_drain();

        test_name = "history";
        for (int n = 0; n < 20; n++) begin
            r = next_rand();
            fetch_then_resolve(random_pc(), 32'h0000_0800, r[20], BR_COND);
        end

        test_name = "alias";
        fetch_then_resolve(pc_a, 32'h0000_8000, 1'b1, BR_UNCOND);
        pc = pc_a ^ 32'h0001_0000;  // tag bit only
        issue_fetch(pc);
        issue_fetch(pc_a);
        wait_drain();

        test_name = "invalidate";
        fetch_then_resolve(pc, 32'h0, 1'b0, BR_NONE);
        issue_fetch(pc_a);
        wait_drain();
        fetch_then_resolve(pc_a, 32'h0, 1'b0, BR_NONE);
        issue_fetch(pc_a);
        wait_drain();

        test_name = "random";
        for (int n = 0; n < 40; n++) begin
            r    = next_rand();
            pc   = random_pc();
            tgt  = {r[31:3], 3'b000};
            kind = br_kind_e'(r[17:16]);
            if (kind == BR_COND) begin
                tkn = r[21];
            end else begin
                tkn = (kind != BR_NONE);
            end
            fetch_then_resolve(pc, tgt, tkn, kind);
        end

        repeat (4) @(posedge clk);
        $display("errors: value %0d, timing %0d, timeout %0d",
                 value_errs, timing_errs, timeout_errs);
        if (value_errs + timing_errs + timeout_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #200_000;
        $display("simulation ran past its time limit");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- branch_predictor.f
verilog/bp_pkg.sv
verilog/bp_table_ram.sv
verilog/bp_fetch_index.sv
verilog/bp_lookup.sv
verilog/bp_update.sv
verilog/branch_predictor.sv
verif/branch_predictor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f branch_predictor.f \
        --top-module branch_predictor_tb \
        --Mdir "$build_dir" -o sim_branch_predictor; then
    echo "verilator build failed"
    exit 1
fi

output=$("./$build_dir/sim_branch_predictor")
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "All checks passed"; then
    exit 0
fi

echo "simulation did not report success"
exit 1
